// ==== hdl/alu_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_exec import riscv_pkg::*;
(
    ex_if.exec              ex,
    output logic            wb_en,
    output logic [4:0]      wb_rd,
    output logic [xlen-1:0] wb_data
);

    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic            lt_signed;
    logic            lt_unsigned;
    logic [xlen-1:0] result;

    // register or immediate second operand
    assign op_b = (ex.alu_src == src_imm) ? ex.imm : ex.op_b;

    // shifts only see the low five bits
    assign shamt = op_b[4:0];

    // set-less-than compares
    assign lt_signed   = $signed(ex.op_a) < $signed(op_b);
    assign lt_unsigned = ex.op_a < op_b;

    always_comb
    begin
        case (ex.alu_op)
            alu_add:   result = ex.op_a + op_b;
            alu_sub:   result = ex.op_a - op_b;
            alu_sll:   result = ex.op_a << shamt;
            alu_slt:   result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu:  result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_xor:   result = ex.op_a ^ op_b;
            alu_srl:   result = ex.op_a >> shamt;
            // arithmetic shift keeps the sign
            alu_sra:   result = xlen'($signed(ex.op_a) >>> shamt);
            alu_or:    result = ex.op_a | op_b;
            alu_and:   result = ex.op_a & op_b;
            // upper immediate passes through
            alu_lui:   result = ex.imm;
            alu_auipc: result = ex.pc + ex.imm;
            default:   result = '0;
        endcase
    end

    // no retire for bubbles or rd of x0
    assign wb_en   = ex.valid && (ex.rd != 5'd0);
    assign wb_rd   = ex.rd;
    assign wb_data = result;

endmodule

`default_nettype wire

// ==== hdl/core_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// fetched word handed from fetch to decode
interface issue_if import riscv_pkg::*; ();
    logic            valid;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr;
    // held high by decode while a hazard is pending
    logic            stall;

    modport fetch  (output valid, pc, instr, input stall);
    modport decode (input valid, pc, instr, output stall);
endinterface

// two combinational read ports into the register file
interface rf_read_if import riscv_pkg::*; ();
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;

    modport decode (output rs1_addr, rs2_addr, input rs1_data, rs2_data);
    modport regs   (input rs1_addr, rs2_addr, output rs1_data, rs2_data);
endinterface

// execute stage register, all driven from decoder flops
interface ex_if import riscv_pkg::*; ();
    logic            valid;
    logic [4:0]      rd;
    alu_op_e         alu_op;
    alu_src_e        alu_src;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] pc;

    modport decode (output valid, rd, alu_op, alu_src, op_a, op_b, imm, pc);
    modport exec   (input valid, rd, alu_op, alu_src, op_a, op_b, imm, pc);
endinterface

`default_nettype wire

// ==== hdl/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder import riscv_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    issue_if.decode   issue,
    rf_read_if.decode rf,
    ex_if.decode      ex
);

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [xlen-1:0] imm;
    alu_op_e         alu_op;
    alu_src_e        alu_src;
    logic            supported;
    logic            uses_rs1;
    logic            uses_rs2;
    logic            hazard;

    // instruction fields
    assign opcode = opcode_e'(issue.instr[6:0]);
    assign rd     = issue.instr[11:7];
    assign funct3 = issue.instr[14:12];
    assign rs1    = issue.instr[19:15];
    assign rs2    = issue.instr[24:20];
    assign funct7 = issue.instr[31:25];

    // operands straight from the register file
    assign rf.rs1_addr = rs1;
    assign rf.rs2_addr = rs2;

    always_comb
    begin
        // i-type immediate unless overridden
        imm       = {{20{issue.instr[31]}}, issue.instr[31:20]};
        alu_op    = alu_add;
        alu_src   = src_imm;
        supported = 1'b0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        case (opcode)
            op_reg:
            begin
                alu_src  = src_rs2;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                // only add/sub and srl/sra have an alternate funct7
                supported = (funct7 == 7'b0000000) ||
                            (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
                case (funct3)
                    3'b000:  alu_op = funct7[5] ? alu_sub : alu_add;
                    3'b001:  alu_op = alu_sll;
                    3'b010:  alu_op = alu_slt;
                    3'b011:  alu_op = alu_sltu;
                    3'b100:  alu_op = alu_xor;
                    3'b101:  alu_op = funct7[5] ? alu_sra : alu_srl;
                    3'b110:  alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
            end
            op_imm:
            begin
                uses_rs1  = 1'b1;
                supported = 1'b1;
                case (funct3)
                    3'b000:  alu_op = alu_add;
                    3'b001:  alu_op = alu_sll;
                    3'b010:  alu_op = alu_slt;
                    3'b011:  alu_op = alu_sltu;
                    3'b100:  alu_op = alu_xor;
                    3'b101:  alu_op = funct7[5] ? alu_sra : alu_srl;
                    3'b110:  alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
                // shift immediates carry funct7 in the upper field
                if (funct3 == 3'b001)
                    supported = (funct7 == 7'b0000000);
                else if (funct3 == 3'b101)
                    supported = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
            end
            op_lui:
            begin
                imm       = {issue.instr[31:12], 12'b0};
                alu_op    = alu_lui;
                supported = 1'b1;
            end
            op_auipc:
            begin
                imm       = {issue.instr[31:12], 12'b0};
                alu_op    = alu_auipc;
                supported = 1'b1;
            end
            // anything else falls through as a skip
            default:
                supported = 1'b0;
        endcase
    end

    // raw hazard against the instruction now in execute
    assign hazard = issue.valid && ex.valid && (ex.rd != 5'd0) &&
                    ((uses_rs1 && rs1 == ex.rd) || (uses_rs2 && rs2 == ex.rd));
    assign issue.stall = hazard;

    // bubble on idle, stall or skipped opcode
    always_ff @(posedge clk)
    begin
        if (reset)
            ex.valid <= 1'b0;
        else
            ex.valid <= issue.valid && !hazard && supported;
    end

    // execute payload, qualified by valid
    always_ff @(posedge clk)
    begin
        ex.rd      <= rd;
        ex.alu_op  <= alu_op;
        ex.alu_src <= alu_src;
        ex.op_a    <= rf.rs1_data;
        ex.op_b    <= rf.rs2_data;
        ex.imm     <= imm;
        ex.pc      <= issue.pc;
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_fsm import riscv_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            timeout,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic [xlen-1:0] wb_adr,
    input  logic [xlen-1:0] wb_dat_i,
    input  logic            wb_ack,
    output logic            fault,
    issue_if.fetch          issue
);

    fetch_state_e    state_q;
    fetch_state_e    state_d;
    // address of the word on the bus or waiting in hold
    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] instr_q;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            // one idle cycle after reset, then start fetching
            fetch_idle:
                state_d = fetch_bus;
            fetch_bus:
            begin
                // ack wins over a timeout in the same cycle
                if (wb_ack)
                    state_d = fetch_hold;
                else if (timeout)
                    state_d = fetch_fault;
            end
            // word presented, leave once decode takes it
            fetch_hold:
            begin
                if (!issue.stall)
                    state_d = fetch_bus;
            end
            // sticky until reset
            default:
                state_d = fetch_fault;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state_q <= fetch_idle;
            pc_q    <= reset_pc;
        end
        else
        begin
            state_q <= state_d;
            // next word once the current one is accepted
            if (state_q == fetch_hold && !issue.stall)
                pc_q <= pc_q + 32'd4;
        end
    end

    // fetched word capture
    always_ff @(posedge clk)
    begin
        if (state_q == fetch_bus && wb_ack)
            instr_q <= wb_dat_i;
    end

    // cyc and stb fall the cycle after ack
    assign wb_cyc = (state_q == fetch_bus);
    assign wb_stb = (state_q == fetch_bus);
    assign wb_adr = pc_q;
    assign fault  = (state_q == fetch_fault);

    assign issue.valid = (state_q == fetch_hold);
    assign issue.pc    = pc_q;
    assign issue.instr = instr_q;

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file import riscv_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    rf_read_if.regs         rf,
    input  logic            wb_en,
    input  logic [4:0]      wb_rd,
    input  logic [xlen-1:0] wb_data
);

    // x0 slot is never written
    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        // writes to x0 dropped here
        else if (wb_en && wb_rd != 5'd0)
        begin
            regs[wb_rd] <= wb_data;
        end
    end

    // no write-through, decode stalls instead
    assign rf.rs1_data = (rf.rs1_addr == 5'd0) ? '0 : regs[rf.rs1_addr];
    assign rf.rs2_data = (rf.rs2_addr == 5'd0) ? '0 : regs[rf.rs2_addr];

endmodule

`default_nettype wire

// ==== hdl/riscv_pkg.sv ====
`default_nettype none

package riscv_pkg;

    // data path width
    localparam int xlen = 32;

    // first fetch address out of reset
    localparam logic [xlen-1:0] reset_pc = '0;

    // unanswered strobe cycles before the bus is declared dead
    localparam int wb_timeout_cycles = 16;
    // wait counter has to reach wb_timeout_cycles itself
    localparam int wb_timer_w = $clog2(wb_timeout_cycles + 1);

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,
        op_imm   = 7'b0010011,
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111
    } opcode_e;

    // alu operations, shared by register and immediate forms
    typedef enum logic [3:0] {
        alu_add   = 4'd0,
        alu_sub   = 4'd1,
        alu_sll   = 4'd2,
        alu_slt   = 4'd3,
        alu_sltu  = 4'd4,
        alu_xor   = 4'd5,
        alu_srl   = 4'd6,
        alu_sra   = 4'd7,
        alu_or    = 4'd8,
        alu_and   = 4'd9,
        alu_lui   = 4'd10,
        alu_auipc = 4'd11
    } alu_op_e;

    // second alu operand select
    typedef enum logic [1:0] {
        src_rs2 = 2'd0,
        src_imm = 2'd1
    } alu_src_e;

    // fetch sequencer states
    typedef enum logic [1:0] {
        fetch_idle,
        fetch_bus,
        fetch_hold,
        fetch_fault
    } fetch_state_e;

endpackage

`default_nettype wire

// ==== hdl/rv_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_top import riscv_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic [xlen-1:0] wb_adr,
    input  logic [xlen-1:0] wb_dat_i,
    input  logic            wb_ack,
    output logic            fault,
    output logic            retire_valid,
    output logic [4:0]      retire_rd,
    output logic [xlen-1:0] retire_data
);

    logic            timeout;
    // writeback from execute into the register file
    logic            wb_en;
    logic [4:0]      wb_rd;
    logic [xlen-1:0] wb_data;

    issue_if   issue_bus ();
    rf_read_if rf_bus ();
    ex_if      ex_bus ();

    fetch_fsm fetch_i (
        .clk      (clk),
        .reset    (reset),
        .timeout  (timeout),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack),
        .fault    (fault),
        .issue    (issue_bus.fetch)
    );

    // watches the strobe for a missing ack
    wb_wait_timer timer_i (
        .clk     (clk),
        .reset   (reset),
        .wb_stb  (wb_stb),
        .wb_ack  (wb_ack),
        .timeout (timeout)
    );

    decoder decoder_i (
        .clk   (clk),
        .reset (reset),
        .issue (issue_bus.decode),
        .rf    (rf_bus.decode),
        .ex    (ex_bus.decode)
    );

    reg_file reg_file_i (
        .clk     (clk),
        .reset   (reset),
        .rf      (rf_bus.regs),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

    alu_exec alu_exec_i (
        .ex      (ex_bus.exec),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

    // every writeback is a retire event
    assign retire_valid = wb_en;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;

endmodule

`default_nettype wire

// ==== hdl/wb_wait_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_wait_timer import riscv_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic wb_stb,
    input  logic wb_ack,
    output logic timeout
);

    // consecutive strobe cycles with no answer
    logic [wb_timer_w-1:0] count_q;

    always_ff @(posedge clk)
    begin
        if (reset)
            count_q <= '0;
        // any answer or idle bus restarts the count
        else if (!wb_stb || wb_ack)
            count_q <= '0;
        // hold at the limit
        else if (!timeout)
            count_q <= count_q + 1'b1;
    end

    assign timeout = (count_q == wb_timer_w'(wb_timeout_cycles));

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the core testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_top \
    -f src.f \
    -o tb_sim

sim_out="$(./obj_dir/tb_sim)"
echo "$sim_out"

if echo "$sim_out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

// ==== src.f ====
hdl/riscv_pkg.sv
hdl/core_ifs.sv
hdl/fetch_fsm.sv
hdl/wb_wait_timer.sv
hdl/decoder.sv
hdl/reg_file.sv
hdl/alu_exec.sv
hdl/rv_core_top.sv
verif/core_properties.sv
verif/tb_top.sv

// ==== verif/core_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_properties import riscv_pkg::*;
(
    input logic            clk,
    input logic            reset,
    input logic            wb_cyc,
    input logic            wb_stb,
    input logic [xlen-1:0] wb_adr,
    input logic            wb_ack,
    input logic            retire_valid,
    input logic [4:0]      retire_rd,
    input logic            stall
);

    // classic bus, strobe only inside a cycle
    stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
        wb_stb |-> wb_cyc)
        else $error("wb_stb high while wb_cyc low");

    // address held until the slave answers
    adr_stable: assert property (@(posedge clk) disable iff (reset)
        (wb_stb && !wb_ack) |=> $stable(wb_adr))
        else $error("wb_adr moved during an unanswered strobe");

    // x0 writes never show up as retires
    no_x0_retire: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> (retire_rd != 5'd0))
        else $error("retire with rd of x0");

    // older instruction drains in one cycle
    stall_one_cycle: assert property (@(posedge clk) disable iff (reset)
        stall |=> !stall)
        else $error("decode stall held for two cycles");

endmodule

`default_nettype wire

// ==== verif/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top import riscv_pkg::*;
();
    localparam int clk_period   = 100;
    localparam int reset_cycles = 16;
    // quiet cycles after the last expected retire
    localparam int drain_cycles = 30;
    // budget per instruction, covers wait states and stalls
    localparam int instr_cycles = 40;
    localparam int max_instrs   = 48;
    localparam int num_tests    = 6;
    localparam int watchdog_cycles = max_instrs * instr_cycles +
                                     num_tests * (reset_cycles + drain_cycles + 4);

    logic            clk;
    logic            reset;
    logic            wb_cyc;
    logic            wb_stb;
    logic [xlen-1:0] wb_adr;
    logic [xlen-1:0] wb_dat_i;
    logic            wb_ack;
    logic            fault;
    logic            retire_valid;
    logic [4:0]      retire_rd;
    logic [xlen-1:0] retire_data;

    // instruction memory seen by the bus model
    logic [xlen-1:0] mem [256];
    logic            ack_enable;
    int unsigned     wait_left;

    // program under construction and its reference results
    logic [xlen-1:0] prog [$];
    logic [4:0]      exp_rd [$];
    logic [xlen-1:0] exp_data [$];
    logic [xlen-1:0] model [32];
    // observed retire events
    logic [4:0]      got_rd [$];
    logic [xlen-1:0] got_data [$];

    int value_errors;
    int other_errors;

    rv_core_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .wb_dat_i     (wb_dat_i),
        .wb_ack       (wb_ack),
        .fault        (fault),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    bind rv_core_top core_properties props_i (
        .clk          (clk),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .wb_ack       (wb_ack),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .stall        (issue_bus.stall)
    );

    always #(clk_period / 2) clk = ~clk;

    // slave side, 0 to 3 wait states per read
    always @(negedge clk)
    begin
        if (wb_ack)
            wb_ack <= 1'b0;
        else if (wb_cyc && wb_stb && ack_enable)
        begin
            if (wait_left == 0)
            begin
                wb_ack    <= 1'b1;
                wb_dat_i  <= mem[wb_adr[9:2]];
                wait_left <= $urandom % 4;
            end
            else
                wait_left <= wait_left - 1;
        end
    end

    // retire monitor
    always @(posedge clk)
    begin
        if (!reset && retire_valid)
        begin
            got_rd.push_back(retire_rd);
            got_data.push_back(retire_data);
        end
    end

    // custom-0 opcode everywhere outside the program
    function automatic logic [xlen-1:0] fill_word(int idx);
        return {~idx[24:0], 7'b0001011};
    endfunction

    function automatic logic [2:0] funct3_of(alu_op_e op);
        case (op)
            alu_sll:          return 3'b001;
            alu_slt:          return 3'b010;
            alu_sltu:         return 3'b011;
            alu_xor:          return 3'b100;
            alu_srl, alu_sra: return 3'b101;
            alu_or:           return 3'b110;
            alu_and:          return 3'b111;
            default:          return 3'b000;
        endcase
    endfunction

    function automatic logic [xlen-1:0] enc_r(alu_op_e op, logic [4:0] rd,
                                              logic [4:0] rs1, logic [4:0] rs2);
        logic [6:0] f7;
        f7 = (op == alu_sub || op == alu_sra) ? 7'b0100000 : 7'b0000000;
        return {f7, rs2, rs1, funct3_of(op), rd, op_reg};
    endfunction

    function automatic logic [xlen-1:0] enc_i(alu_op_e op, logic [4:0] rd,
                                              logic [4:0] rs1, logic [11:0] imm);
        logic [11:0] field;
        field = imm;
        // shift forms carry funct7 above shamt
        if (op == alu_sll || op == alu_srl)
            field = {7'b0000000, imm[4:0]};
        else if (op == alu_sra)
            field = {7'b0100000, imm[4:0]};
        return {field, rs1, funct3_of(op), rd, op_imm};
    endfunction

    // rv32i semantics, shift amount from the low five bits
    function automatic logic [xlen-1:0] ref_alu(alu_op_e op, logic [xlen-1:0] a,
                                                logic [xlen-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_sll:  return a << sh;
            alu_slt:  return {31'b0, ($signed(a) < $signed(b))};
            alu_sltu: return {31'b0, (a < b)};
            alu_xor:  return a ^ b;
            alu_srl:  return a >> sh;
            // sign fill of the vacated upper bits
            alu_sra:  return a[31] ? ((a >> sh) | ~({xlen{1'b1}} >> sh)) : (a >> sh);
            alu_or:   return a | b;
            alu_and:  return a & b;
            default:  return '0;
        endcase
    endfunction

    task automatic record(logic [4:0] rd, logic [xlen-1:0] val);
        if (rd != 5'd0)
        begin
            model[rd] = val;
            exp_rd.push_back(rd);
            exp_data.push_back(val);
        end
    endtask

    task automatic begin_program();
        prog.delete();
        exp_rd.delete();
        exp_data.delete();
        foreach (model[i])
            model[i] = '0;
    endtask

    task automatic emit_r(alu_op_e op, logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        prog.push_back(enc_r(op, rd, rs1, rs2));
        record(rd, ref_alu(op, model[rs1], model[rs2]));
    endtask

    task automatic emit_i(alu_op_e op, logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        prog.push_back(enc_i(op, rd, rs1, imm));
        record(rd, ref_alu(op, model[rs1], {{20{imm[11]}}, imm}));
    endtask

    // lui or auipc, pc is the word's byte address
    task automatic emit_upper(opcode_e opc, logic [4:0] rd, logic [19:0] imm20);
        logic [xlen-1:0] pc;
        pc = prog.size() * 4;
        prog.push_back({imm20, rd, opc});
        record(rd, {imm20, 12'b0} + ((opc == op_auipc) ? pc : '0));
    endtask

    // unsupported word, nothing retires
    task automatic emit_raw(logic [xlen-1:0] word);
        prog.push_back(word);
    endtask

    task automatic check_rd(string sig, logic [4:0] expected, logic [4:0] actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("Fail at %0t: %s expected %0d, got %0d", $time, sig, expected, actual);
        end
    endtask

    task automatic check_data(string sig, logic [xlen-1:0] expected,
                              logic [xlen-1:0] actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("Fail at %0t: %s expected %h, got %h", $time, sig, expected, actual);
        end
    endtask

    // memory loaded while the core sits in reset
    task automatic load_and_reset();
        @(negedge clk);
        reset = 1'b1;
        foreach (mem[i])
            mem[i] = fill_word(i);
        foreach (prog[i])
            mem[8'(i)] = prog[i];
        repeat (reset_cycles) @(negedge clk);
        got_rd.delete();
        got_data.delete();
        reset = 1'b0;
    endtask

    task automatic run_program(string name);
        int limit;
        int cycles;
        int n;
        load_and_reset();
        limit  = prog.size() * instr_cycles;
        cycles = 0;
        while (got_rd.size() < exp_rd.size() && cycles < limit)
        begin
            @(negedge clk);
            cycles++;
        end
        repeat (drain_cycles) @(negedge clk);
        n = (got_rd.size() < exp_rd.size()) ? got_rd.size() : exp_rd.size();
        for (int i = 0; i < n; i++)
        begin
            check_rd("retire_rd", exp_rd[i], got_rd[i]);
            check_data("retire_data", exp_data[i], got_data[i]);
        end
        if (got_rd.size() < exp_rd.size())
        begin
            other_errors++;
            $display("%s: only %0d of %0d expected retires arrived", name,
                     got_rd.size(), exp_rd.size());
        end
        else if (got_rd.size() > exp_rd.size())
        begin
            other_errors++;
            $display("%s: %0d retires seen where %0d were expected", name,
                     got_rd.size(), exp_rd.size());
        end
    endtask

    // operands preloaded through addi
    task automatic test_r_type();
        begin_program();
        emit_i(alu_add, 5'd1, 5'd0, 12'd23);
        emit_i(alu_add, 5'd2, 5'd0, 12'hff9);
        emit_i(alu_add, 5'd3, 5'd0, 12'd3);
        emit_r(alu_add, 5'd4, 5'd1, 5'd2);
        emit_r(alu_sub, 5'd5, 5'd1, 5'd2);
        emit_r(alu_sll, 5'd6, 5'd1, 5'd3);
        emit_r(alu_slt, 5'd7, 5'd2, 5'd1);
        emit_r(alu_sltu, 5'd8, 5'd2, 5'd1);
        emit_r(alu_xor, 5'd9, 5'd1, 5'd2);
        emit_r(alu_srl, 5'd10, 5'd2, 5'd3);
        emit_r(alu_sra, 5'd11, 5'd2, 5'd3);
        emit_r(alu_or, 5'd12, 5'd1, 5'd2);
        emit_r(alu_and, 5'd13, 5'd1, 5'd2);
        run_program("r-type");
    endtask

    // negative immediates, sign extension
    task automatic test_i_type();
        begin_program();
        emit_i(alu_add, 5'd1, 5'd0, 12'hf9c);
        emit_i(alu_add, 5'd2, 5'd1, 12'h800);
        emit_i(alu_slt, 5'd3, 5'd1, 12'hf9d);
        emit_i(alu_sltu, 5'd4, 5'd1, 12'hfff);
        emit_i(alu_xor, 5'd5, 5'd1, 12'hfff);
        emit_i(alu_or, 5'd6, 5'd1, 12'h0f0);
        emit_i(alu_and, 5'd7, 5'd1, 12'hff0);
        emit_i(alu_sll, 5'd8, 5'd1, 12'd4);
        emit_i(alu_srl, 5'd9, 5'd1, 12'd28);
        emit_i(alu_sra, 5'd10, 5'd1, 12'd3);
        run_program("i-type");
    endtask

    task automatic test_upper();
        begin_program();
        emit_upper(op_lui, 5'd1, 20'habcde);
        emit_upper(op_auipc, 5'd2, 20'h00001);
        emit_upper(op_auipc, 5'd3, 20'hfffff);
        emit_upper(op_lui, 5'd4, 20'h80000);
        emit_i(alu_add, 5'd5, 5'd1, 12'h123);
        run_program("upper");
    endtask

    // every step reads the previous rd, forces stalls
    task automatic test_dependent_chain();
        begin_program();
        emit_i(alu_add, 5'd1, 5'd0, 12'd5);
        emit_r(alu_add, 5'd2, 5'd1, 5'd1);
        emit_r(alu_add, 5'd3, 5'd2, 5'd2);
        emit_r(alu_or, 5'd4, 5'd3, 5'd3);
        emit_i(alu_sll, 5'd5, 5'd4, 12'd3);
        emit_r(alu_sub, 5'd5, 5'd5, 5'd4);
        emit_i(alu_sra, 5'd6, 5'd5, 12'd2);
        emit_i(alu_add, 5'd6, 5'd6, 12'hfff);
        run_program("chain");
    endtask

    task automatic test_x0_and_skip();
        begin_program();
        emit_i(alu_add, 5'd1, 5'd0, 12'd9);
        emit_i(alu_add, 5'd0, 5'd1, 12'd5);
        emit_r(alu_add, 5'd0, 5'd1, 5'd1);
        // ecall, store, and mul
        emit_raw(32'h0000_0073);
        emit_raw(32'h0010_2023);
        emit_raw({7'b0000001, 5'd1, 5'd1, 3'b000, 5'd7, op_reg});
        emit_r(alu_add, 5'd2, 5'd0, 5'd1);
        emit_r(alu_add, 5'd4, 5'd0, 5'd0);
        run_program("x0 and skip");
    endtask

    // slave never answers
    task automatic test_bus_timeout();
        int limit;
        int cycles;
        int stb_cycles;
        begin_program();
        emit_i(alu_add, 5'd1, 5'd0, 12'd1);
        emit_i(alu_add, 5'd2, 5'd0, 12'd2);
        ack_enable = 1'b0;
        load_and_reset();
        limit      = prog.size() * instr_cycles;
        cycles     = 0;
        stb_cycles = 0;
        while (!fault && cycles < limit)
        begin
            @(negedge clk);
            cycles++;
            if (wb_stb)
                stb_cycles++;
        end
        if (fault !== 1'b1)
        begin
            other_errors++;
            $display("timeout: fault never rose with ack withheld");
        end
        else if (stb_cycles < wb_timeout_cycles)
        begin
            other_errors++;
            $display("timeout: fault after only %0d wait states", stb_cycles);
        end
        repeat (drain_cycles) @(negedge clk);
        if (got_rd.size() != 0)
        begin
            other_errors++;
            $display("timeout: %0d retires seen with no bus answer", got_rd.size());
        end
        if (wb_stb !== 1'b0 || wb_cyc !== 1'b0)
        begin
            other_errors++;
            $display("timeout: bus cycle still open after the fault");
        end
        ack_enable = 1'b1;
    endtask

    initial
    begin
        clk          = 1'b0;
        reset        = 1'b1;
        wb_ack       = 1'b0;
        wb_dat_i     = '0;
        ack_enable   = 1'b1;
        wait_left    = 0;
        value_errors = 0;
        other_errors = 0;
        void'($urandom(32'hcadf2cd5));
        test_r_type();
        test_i_type();
        test_upper();
        test_dependent_chain();
        test_x0_and_skip();
        test_bus_timeout();
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // backstop for a core that never finishes
    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles", watchdog_cycles);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire
